//--- dv/fetch_assertions.sv
/*
 Protocol assertions for the fetch front end, attached to fetch_top by bind.
 Covers request stability, the queue push handshake and decode valid order.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions
   import fetch_cfg_pkg::*;
(
   input logic                clk,
   input logic                reset_i,
   input logic                flush_i,
   input logic                req_valid_i,
   input logic                req_ready_i,
   input addr_t               req_addr_i,
   input logic                push_valid_i,
   input logic                push_ready_i,
   input logic [ISSUE_W-1:0]  id_valid_i
);

   // Stalled request holds until accepted or redirected
   req_stable: assert property (
      @(posedge clk) disable iff (reset_i)
      (req_valid_i && !req_ready_i && !flush_i) |=> (req_valid_i && $stable(req_addr_i))
   ) else $error("memory request dropped or changed while the memory held it off");

   push_ready: assert property (
      @(posedge clk) disable iff (reset_i)
      push_valid_i |-> push_ready_i
   ) else $error("window pushed into the fetch queue while it was not ready");

   // Slot 1 never valid without slot 0
   id_contiguous: assert property (
      @(posedge clk) disable iff (reset_i)
      id_valid_i[1] |-> id_valid_i[0]
   ) else $error("decode slot 1 valid while slot 0 is empty");

endmodule

bind fetch_top fetch_assertions U_ASSERT (
   .clk          (clk),
   .reset_i      (reset_i),
   .flush_i      (flush_i),
   .req_valid_i  (mem_req_valid_o),
   .req_ready_i  (mem_req_ready_i),
   .req_addr_i   (mem_req_addr_o),
   .push_valid_i (bundle.valid),
   .push_ready_i (bundle.ready),
   .id_valid_i   (id_valid_o)
);

`default_nettype wire

//--- dv/tb_fetch_top.sv
/*
 Testbench for the fetch front end. Random memory latency, pops, flushes and
 BTB updates; every instruction taken by decode is checked against a BTB model
 and an expected PC stream. Built and run by run_verilator.sh.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top
   import fetch_cfg_pkg::*;
   import bpu_pkg::*;
#(
   parameter int FQ_DEPTH = 8
)
();

   localparam int    BTB_ENTRIES     = 16;
   localparam int    CLK_PERIOD      = 100;
   localparam int    RESET_CYCLES    = 4;
   localparam int    TEST_CYCLES     = 3000;
   localparam int    FLUSH_GAP_MIN   = 30;
   localparam int    FLUSH_GAP_RNG   = 21;
   localparam int    MAX_FLUSHES     = TEST_CYCLES / FLUSH_GAP_MIN + 1;
   localparam int    WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 50 * MAX_FLUSHES;
   localparam int    IDLE_LIMIT      = 100;
   localparam int    MIN_POPS        = 300;
   // Flush targets and branch PCs share one small code region
   localparam addr_t REGION_BASE     = 32'h0000_1000;
   localparam int    REGION_INSNS    = 32;

   logic                      clk;
   logic                      reset_i;
   logic                      mem_req_valid_o;
   logic                      mem_req_ready_i;
   addr_t                     mem_req_addr_o;
   logic                      mem_rsp_valid_i;
   logic [FETCH_W*INSN_W-1:0] mem_rsp_data_i;
   logic  [ISSUE_W-1:0]       id_valid_o;
   insn_t [ISSUE_W-1:0]       id_ins_o;
   addr_t [ISSUE_W-1:0]       id_pc_o;
   logic  [ISSUE_W-1:0]       id_pred_taken_o;
   addr_t [ISSUE_W-1:0]       id_pred_target_o;
   logic  [CNT_W-1:0]         id_pop_cnt_i;
   logic                      flush_i;
   addr_t                     flush_tgt_i;
   logic                      bpu_wb_i;
   br_kind_e                  bpu_wb_kind_i;
   logic                      bpu_wb_taken_i;
   addr_t                     bpu_wb_pc_i;
   addr_t                     bpu_wb_target_i;

   // BTB model with one entry per index holding the owning branch PC
   logic  mdl_vld [BTB_ENTRIES];
   addr_t mdl_pc  [BTB_ENTRIES];
   addr_t mdl_tgt [BTB_ENTRIES];
   ctr_t  mdl_ctr [BTB_ENTRIES];

   addr_t exp_pc;
   addr_t rsp_addr;
   int    rsp_delay;
   int    n_flushes;
   int    n_pops;
   int    idle_cycles;
   int    hold_cycles;
   int    flush_gap;
   string test_name;

   fetch_top #(
      .FQ_DEPTH    (FQ_DEPTH),
      .BTB_ENTRIES (BTB_ENTRIES)
   ) DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("Regression failed");
      $display("%s", why);
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_addr(input string what, input addr_t exp, input addr_t act);
      if (exp !== act)
         stop_run($sformatf("mismatch %s %s expected %h actual %h", test_name, what, exp, act));
   endtask

   task automatic check_insn(input string what, input insn_t exp, input insn_t act);
      if (exp !== act)
         stop_run($sformatf("mismatch %s %s expected %h actual %h", test_name, what, exp, act));
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (exp !== act)
         stop_run($sformatf("mismatch %s %s expected %b actual %b", test_name, what, exp, act));
   endtask

   // Memory contents as a hash of the full byte address
   function automatic insn_t insn_at(addr_t addr);
      insn_t h;
      h = addr * 32'h9E37_79B1;
      return h ^ (addr >> 11) ^ 32'hC3A5_0F1E;
   endfunction

   function automatic addr_t region_addr();
      return REGION_BASE + addr_t'(INSN_BYTES * ($urandom % REGION_INSNS));
   endfunction

   function automatic int btb_slot(addr_t pc);
      return int'((pc / INSN_BYTES) % BTB_ENTRIES);
   endfunction

   function automatic logic predict_taken(addr_t pc);
      int i;
      i = btb_slot(pc);
      return mdl_vld[i] && (mdl_pc[i] / INSN_BYTES == pc / INSN_BYTES) && (mdl_ctr[i] >= 2'd2);
   endfunction

   function automatic addr_t next_pc(addr_t pc);
      return predict_taken(pc) ? mdl_tgt[btb_slot(pc)] : pc + addr_t'(INSN_BYTES);
   endfunction

   task automatic btb_train(input br_kind_e kind, input logic taken, input addr_t pc,
                            input addr_t tgt);
      int   i;
      logic hit;
      i   = btb_slot(pc);
      hit = mdl_vld[i] && (mdl_pc[i] / INSN_BYTES == pc / INSN_BYTES);
      if (kind == BR_JUMP || taken)
      begin
         if (kind == BR_JUMP)
            mdl_ctr[i] = 2'd3;
         else if (!hit)
            mdl_ctr[i] = 2'd2;
         else if (mdl_ctr[i] != 2'd3)
            mdl_ctr[i] = mdl_ctr[i] + 2'd1;
         mdl_vld[i] = 1'b1;
         mdl_pc[i]  = pc;
         mdl_tgt[i] = tgt;
      end
      else if (hit && mdl_ctr[i] != 2'd0)
         mdl_ctr[i] = mdl_ctr[i] - 2'd1;
   endtask

   // Serves one request at a time with the response 1 to 4 cycles after acceptance
   task automatic drive_memory();
      mem_rsp_valid_i = 1'b0;
      if (rsp_delay > 0)
      begin
         rsp_delay--;
         if (rsp_delay == 0)
         begin
            mem_rsp_valid_i = 1'b1;
            mem_rsp_data_i  = {insn_at(rsp_addr + addr_t'(INSN_BYTES)), insn_at(rsp_addr)};
         end
      end
      mem_req_ready_i = ($urandom % 4) != 0;
      if (mem_req_valid_o && mem_req_ready_i)
      begin
         if (rsp_delay != 0 || mem_rsp_valid_i)
            stop_run("a memory request was accepted while a response was outstanding");
         check_addr("request alignment", '0, mem_req_addr_o & addr_t'(WIN_BYTES - 1));
         rsp_addr  = mem_req_addr_o;
         rsp_delay = 1 + $urandom % 4;
      end
   endtask

   task automatic drive_flush();
      flush_i     = 1'b1;
      flush_tgt_i = region_addr();
      exp_pc      = flush_tgt_i;
      n_flushes++;
      if ($urandom % 2 == 0)
      begin
         bpu_wb_i        = 1'b1;
         bpu_wb_kind_i   = ($urandom % 3 == 0) ? BR_JUMP : BR_COND;
         bpu_wb_taken_i  = ($urandom % 4) != 0;
         bpu_wb_pc_i     = region_addr();
         bpu_wb_target_i = region_addr();
         btb_train(bpu_wb_kind_i, bpu_wb_taken_i, bpu_wb_pc_i, bpu_wb_target_i);
      end
   endtask

   // Checks the slots decode is about to take in program order
   task automatic take_pops(input int cnt);
      for (int s = 0; s < cnt; s++)
      begin
         check_addr("decode pc", exp_pc, id_pc_o[s]);
         check_insn("decode instruction", insn_at(exp_pc), id_ins_o[s]);
         check_bit("decode predicted taken", predict_taken(exp_pc), id_pred_taken_o[s]);
         check_addr("decode predicted target", next_pc(exp_pc), id_pred_target_o[s]);
         exp_pc = next_pc(exp_pc);
      end
   endtask

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      stop_run("watchdog expired before the test cycles completed");
   end

   initial
   begin
      int n_valid;
      int pop;
      void'($urandom(32'he729));
      reset_i         = 1'b1;
      mem_req_ready_i = 1'b0;
      mem_rsp_valid_i = 1'b0;
      mem_rsp_data_i  = '0;
      id_pop_cnt_i    = '0;
      flush_i         = 1'b0;
      flush_tgt_i     = '0;
      bpu_wb_i        = 1'b0;
      bpu_wb_kind_i   = BR_COND;
      bpu_wb_taken_i  = 1'b0;
      bpu_wb_pc_i     = '0;
      bpu_wb_target_i = '0;
      for (int i = 0; i < BTB_ENTRIES; i++)
         mdl_vld[i] = 1'b0;
      exp_pc      = '0;
      rsp_delay   = 0;
      n_flushes   = 0;
      n_pops      = 0;
      idle_cycles = 0;
      hold_cycles = 0;
      flush_gap   = FLUSH_GAP_MIN + $urandom % FLUSH_GAP_RNG;
      test_name   = "reset";

      repeat (RESET_CYCLES) @(negedge clk);
      reset_i = 1'b0;
      check_bit("decode slot 0 valid", 1'b0, id_valid_o[0]);
      check_bit("decode slot 1 valid", 1'b0, id_valid_o[1]);

      for (int cyc = 0; cyc < TEST_CYCLES; cyc++)
      begin
         flush_i  = 1'b0;
         bpu_wb_i = 1'b0;
         pop      = 0;
         if (hold_cycles > 0)
            test_name = "pop hold";
         else if (n_flushes == 0)
            test_name = "sequential fetch";
         else
            test_name = "flush and predict";
         drive_memory();
         n_valid = int'(id_valid_o[0]) + int'(id_valid_o[1]);
         if (flush_gap == 0)
         begin
            drive_flush();
            flush_gap = FLUSH_GAP_MIN + $urandom % FLUSH_GAP_RNG;
         end
         else
         begin
            flush_gap--;
            if (hold_cycles == 0 && $urandom % 200 == 0)
               hold_cycles = 20 + $urandom % 41;
            if (hold_cycles > 0)
               hold_cycles--;
            else
               pop = $urandom % (n_valid + 1);
            take_pops(pop);
         end
         id_pop_cnt_i = CNT_W'(pop);
         n_pops += pop;
         // A live front end keeps decode fed unless decode is stalled
         if (pop > 0 || flush_i || hold_cycles > 0)
            idle_cycles = 0;
         else
            idle_cycles++;
         if (idle_cycles > IDLE_LIMIT)
            stop_run("no instruction reached decode within the idle limit");
         @(negedge clk);
      end

      if (n_pops < MIN_POPS)
         stop_run($sformatf("only %0d instructions reached decode", n_pops));
      else
      begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- run_verilator.sh
#!/bin/sh
# Builds and runs the fetch testbench with an 8 entry and a 4 entry fetch queue
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_fetch_top \
   -GFQ_DEPTH=8 --Mdir obj_fq8 -o sim_fq8 && ./obj_fq8/sim_fq8 &&
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_fetch_top \
   -GFQ_DEPTH=4 --Mdir obj_fq4 -o sim_fq4 && ./obj_fq4/sim_fq4 || exit 1

//--- sources.f
verilog/fetch_cfg_pkg.sv
verilog/bpu_pkg.sv
verilog/fetch_bundle_if.sv
verilog/bpu_lookup_if.sv
verilog/fetch_pc_gen.sv
verilog/branch_predictor.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
dv/fetch_assertions.sv
dv/tb_fetch_top.sv

//--- verilog/bpu_lookup_if.sv
/*
 Combinational BTB lookup of both slot PCs of the current fetch window.
*/
`timescale 1ns/1ps
`default_nettype none

interface bpu_lookup_if
   import fetch_cfg_pkg::*;
();

   addr_t lookup_pc0;
   addr_t lookup_pc1;
   logic  hit0;
   logic  taken0;
   addr_t target0;
   logic  hit1;
   logic  taken1;
   addr_t target1;

   modport requester (
      output lookup_pc0, lookup_pc1,
      input  hit0, taken0, target0, hit1, taken1, target1
   );

   modport predictor (
      input  lookup_pc0, lookup_pc1,
      output hit0, taken0, target0, hit1, taken1, target1
   );

endinterface

`default_nettype wire

//--- verilog/bpu_pkg.sv
/*
 Branch predictor definitions. Writeback update kinds and the 2-bit
 saturating counter with its named levels.
*/
`default_nettype none

package bpu_pkg;

   typedef enum logic {
      BR_COND = 1'b0,
      BR_JUMP = 1'b1
   } br_kind_e;

   typedef logic [1:0] ctr_t;

   // Counter levels where weakly taken and above predict taken
   localparam ctr_t CTR_STRONG_NT    = 2'd0;
   localparam ctr_t CTR_WEAK_NT      = 2'd1;
   localparam ctr_t CTR_WEAK_TAKEN   = 2'd2;
   localparam ctr_t CTR_STRONG_TAKEN = 2'd3;

   // Step size of a counter move
   localparam ctr_t CTR_STEP         = 2'd1;

endpackage

`default_nettype wire

//--- verilog/branch_predictor.sv
/*
 Direct-mapped BTB with 2-bit counters. Two combinational lookups per
 cycle; resolved branches update or allocate entries at the clock edge.
*/
`timescale 1ns/1ps
`default_nettype none

module branch_predictor
   import fetch_cfg_pkg::*;
   import bpu_pkg::*;
#(
   parameter int BTB_ENTRIES = 16
)
(
   input  logic               clk,
   input  logic               reset_i,
   bpu_lookup_if.predictor    bpu,
   input  logic               bpu_wb_i,
   input  br_kind_e           bpu_wb_kind_i,
   input  logic               bpu_wb_taken_i,
   input  addr_t              bpu_wb_pc_i,
   input  addr_t              bpu_wb_target_i
);

   localparam int IDX_W = $clog2(BTB_ENTRIES);
   localparam int TAG_W = ADDR_W - INSN_OFF_W - IDX_W;

   logic [BTB_ENTRIES-1:0]  btb_vld;
   logic [TAG_W-1:0]        btb_tag [BTB_ENTRIES];
   addr_t                   btb_tgt [BTB_ENTRIES];
   ctr_t                    btb_ctr [BTB_ENTRIES];

   logic [IDX_W-1:0]        idx0;
   logic [IDX_W-1:0]        idx1;
   logic [IDX_W-1:0]        wb_idx;
   logic                    wb_hit;
   logic                    wb_write;
   logic                    wb_tgt_write;
   ctr_t                    ctr_d;

   function automatic logic [IDX_W-1:0] idx_of(addr_t pc);
      return pc[INSN_OFF_W +: IDX_W];
   endfunction

   function automatic logic [TAG_W-1:0] tag_of(addr_t pc);
      return pc[ADDR_W-1 -: TAG_W];
   endfunction

   assign idx0 = idx_of(bpu.lookup_pc0);
   assign idx1 = idx_of(bpu.lookup_pc1);

   assign bpu.hit0    = btb_vld[idx0] && (btb_tag[idx0] == tag_of(bpu.lookup_pc0));
   assign bpu.taken0  = bpu.hit0 && (btb_ctr[idx0] >= CTR_WEAK_TAKEN);
   assign bpu.target0 = btb_tgt[idx0];
   assign bpu.hit1    = btb_vld[idx1] && (btb_tag[idx1] == tag_of(bpu.lookup_pc1));
   assign bpu.taken1  = bpu.hit1 && (btb_ctr[idx1] >= CTR_WEAK_TAKEN);
   assign bpu.target1 = btb_tgt[idx1];

   assign wb_idx = idx_of(bpu_wb_pc_i);
   assign wb_hit = btb_vld[wb_idx] && (btb_tag[wb_idx] == tag_of(bpu_wb_pc_i));

   // Misses allocate only for jumps and taken conditionals
   assign wb_write     = bpu_wb_i && (wb_hit || bpu_wb_kind_i == BR_JUMP || bpu_wb_taken_i);
   assign wb_tgt_write = wb_write && (bpu_wb_kind_i == BR_JUMP || bpu_wb_taken_i);

   always_comb
   begin
      if (bpu_wb_kind_i == BR_JUMP)
         ctr_d = CTR_STRONG_TAKEN;
      else if (!wb_hit)
         ctr_d = bpu_wb_taken_i ? CTR_WEAK_TAKEN : CTR_WEAK_NT;
      else if (bpu_wb_taken_i)
         ctr_d = (btb_ctr[wb_idx] == CTR_STRONG_TAKEN) ? CTR_STRONG_TAKEN
                                                       : btb_ctr[wb_idx] + CTR_STEP;
      else
         ctr_d = (btb_ctr[wb_idx] == CTR_STRONG_NT) ? CTR_STRONG_NT
                                                    : btb_ctr[wb_idx] - CTR_STEP;
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
         btb_vld <= '0;
      else if (wb_write)
         btb_vld[wb_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (wb_write)
      begin
         btb_tag[wb_idx] <= tag_of(bpu_wb_pc_i);
         btb_ctr[wb_idx] <= ctr_d;
      end
      if (wb_tgt_write)
         btb_tgt[wb_idx] <= bpu_wb_target_i;
   end

endmodule

`default_nettype wire

//--- verilog/fetch_bundle_if.sv
/*
 Fetched window handed from the PC generator to the fetch queue.
 Transfers on valid and ready; ready means two entries are free.
*/
`timescale 1ns/1ps
`default_nettype none

interface fetch_bundle_if
   import fetch_cfg_pkg::*;
();

   logic                 valid;
   logic                 ready;
   // Address of the first pushed instruction
   addr_t                pc;
   // Pushed instructions, compacted to start at index 0
   insn_t [FETCH_W-1:0]  ins;
   logic  [CNT_W-1:0]    count;
   // Prediction of the last pushed instruction
   logic                 pred_taken;
   addr_t                pred_target;

   modport pc_gen (
      output valid, pc, ins, count, pred_taken, pred_target,
      input  ready
   );

   modport queue (
      input  valid, pc, ins, count, pred_taken, pred_target,
      output ready
   );

endinterface

`default_nettype wire

//--- verilog/fetch_cfg_pkg.sv
/*
 Fetch front end configuration. Address and instruction types, window
 geometry and the PC generator state encoding, shared by every fetch block.
*/
`default_nettype none

package fetch_cfg_pkg;

   localparam int ADDR_W     = 32;
   localparam int INSN_W     = 32;
   localparam int FETCH_W    = 2;
   localparam int ISSUE_W    = 2;

   // Byte geometry of one instruction and one fetch window
   localparam int INSN_BYTES = INSN_W / 8;
   localparam int INSN_OFF_W = $clog2(INSN_BYTES);
   localparam int WIN_BYTES  = FETCH_W * INSN_BYTES;
   localparam int WIN_OFF_W  = $clog2(WIN_BYTES);

   // Wide enough for a push or pop count of 0..2
   localparam int CNT_W      = $clog2(FETCH_W + 1);

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [INSN_W-1:0] insn_t;

   typedef enum logic [1:0] {
      FETCH_REQ  = 2'd0,
      FETCH_WAIT = 2'd1,
      FETCH_DROP = 2'd2
   } fetch_state_e;

endpackage

`default_nettype wire

//--- verilog/fetch_pc_gen.sv
/*
 PC generator. Holds the fetch PC, issues one window request at a time,
 masks the response by PC offset and prediction, and picks the next PC.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen
   import fetch_cfg_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset_i,
   input  logic                      flush_i,
   input  addr_t                     flush_tgt_i,
   output logic                      mem_req_valid_o,
   input  logic                      mem_req_ready_i,
   output addr_t                     mem_req_addr_o,
   input  logic                      mem_rsp_valid_i,
   input  logic [FETCH_W*INSN_W-1:0] mem_rsp_data_i,
   fetch_bundle_if.pc_gen            bundle,
   bpu_lookup_if.requester           bpu
);

   fetch_state_e                      state_q;
   fetch_state_e                      state_d;
   addr_t                             pc_q;
   addr_t                             pc_d;
   addr_t                             win_pc;
   addr_t                             pred_pc;
   logic [WIN_OFF_W-INSN_OFF_W-1:0]   slot_pos;
   logic                              slot0_vld;
   logic                              slot1_vld;
   logic                              take0;
   logic                              take1;
   logic                              push;

   assign win_pc   = {pc_q[ADDR_W-1:WIN_OFF_W], {WIN_OFF_W{1'b0}}};
   assign slot_pos = pc_q[WIN_OFF_W-1:INSN_OFF_W];

   assign bpu.lookup_pc0 = win_pc;
   assign bpu.lookup_pc1 = win_pc + addr_t'(INSN_BYTES);

   // Slot 0 only counts when the PC points at it
   assign slot0_vld = (slot_pos == '0);
   assign take0     = slot0_vld & bpu.hit0 & bpu.taken0;
   // Slot 1 is dropped behind a taken slot 0
   assign slot1_vld = ~take0;
   assign take1     = slot1_vld & bpu.hit1 & bpu.taken1;

   always_comb
   begin
      if (take0)
         pred_pc = bpu.target0;
      else if (take1)
         pred_pc = bpu.target1;
      else
         pred_pc = win_pc + addr_t'(WIN_BYTES);
   end

   assign mem_req_valid_o = (state_q == FETCH_REQ) & bundle.ready;
   assign mem_req_addr_o  = win_pc;

   // A response racing a flush is thrown away
   assign push = (state_q == FETCH_WAIT) & mem_rsp_valid_i & ~flush_i;

   assign bundle.valid       = push;
   assign bundle.pc          = pc_q;
   assign bundle.ins[0]      = slot0_vld ? mem_rsp_data_i[INSN_W-1:0]
                                         : mem_rsp_data_i[2*INSN_W-1:INSN_W];
   assign bundle.ins[1]      = mem_rsp_data_i[2*INSN_W-1:INSN_W];
   assign bundle.count       = CNT_W'(slot0_vld) + CNT_W'(slot1_vld);
   assign bundle.pred_taken  = take0 | take1;
   // Predicted next PC after the last pushed instruction
   assign bundle.pred_target = pred_pc;

   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         FETCH_REQ:
         begin
            if (mem_req_valid_o && mem_req_ready_i)
               state_d = flush_i ? FETCH_DROP : FETCH_WAIT;
         end
         FETCH_WAIT:
         begin
            if (mem_rsp_valid_i)
               state_d = FETCH_REQ;
            else if (flush_i)
               state_d = FETCH_DROP;
         end
         FETCH_DROP:
         begin
            if (mem_rsp_valid_i)
               state_d = FETCH_REQ;
         end
         default:
            state_d = FETCH_REQ;
      endcase
   end

   always_comb
   begin
      if (flush_i)
         pc_d = flush_tgt_i;
      else if (push)
         pc_d = pred_pc;
      else
         pc_d = pc_q;
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         state_q <= FETCH_REQ;
         pc_q    <= '0;
      end
      else
      begin
         state_q <= state_d;
         pc_q    <= pc_d;
      end
   end

endmodule

`default_nettype wire

//--- verilog/fetch_queue.sv
/*
 Fetch queue between the PC generator and decode. Circular buffer taking
 up to two instructions per push and offering the two oldest to decode.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
   import fetch_cfg_pkg::*;
#(
   parameter int FQ_DEPTH = 8
)
(
   input  logic                 clk,
   input  logic                 reset_i,
   input  logic                 flush_i,
   fetch_bundle_if.queue        bundle,
   output logic  [ISSUE_W-1:0]  id_valid_o,
   output insn_t [ISSUE_W-1:0]  id_ins_o,
   output addr_t [ISSUE_W-1:0]  id_pc_o,
   output logic  [ISSUE_W-1:0]  id_pred_taken_o,
   output addr_t [ISSUE_W-1:0]  id_pred_target_o,
   input  logic  [CNT_W-1:0]    id_pop_cnt_i
);

   localparam int IDX_W = $clog2(FQ_DEPTH);
   localparam int PTR_W = IDX_W + 1;

   insn_t                fq_ins   [FQ_DEPTH];
   addr_t                fq_pc    [FQ_DEPTH];
   addr_t                fq_tgt   [FQ_DEPTH];
   logic [FQ_DEPTH-1:0]  fq_taken;

   // Extra pointer bit tells full from empty
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [PTR_W-1:0]     used;
   logic                 push;

   assign used         = wr_ptr - rd_ptr;
   assign bundle.ready = (used <= PTR_W'(FQ_DEPTH - FETCH_W));
   assign push         = bundle.valid & bundle.ready;

   always_ff @(posedge clk)
   begin
      if (reset_i || flush_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         rd_ptr <= rd_ptr + PTR_W'(id_pop_cnt_i);
         if (push)
            wr_ptr <= wr_ptr + PTR_W'(bundle.count);
      end
   end

   // Only the last pushed slot carries the window prediction
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         for (int s = 0; s < FETCH_W; s++)
         begin
            if (CNT_W'(s) < bundle.count)
            begin
               fq_ins[wr_ptr[IDX_W-1:0] + IDX_W'(s)] <= bundle.ins[s];
               fq_pc[wr_ptr[IDX_W-1:0] + IDX_W'(s)]  <=
                  bundle.pc + addr_t'(s * INSN_BYTES);
               if (CNT_W'(s + 1) == bundle.count)
               begin
                  fq_taken[wr_ptr[IDX_W-1:0] + IDX_W'(s)] <= bundle.pred_taken;
                  fq_tgt[wr_ptr[IDX_W-1:0] + IDX_W'(s)]   <= bundle.pred_target;
               end
               else
               begin
                  fq_taken[wr_ptr[IDX_W-1:0] + IDX_W'(s)] <= 1'b0;
                  // Falls through to the next slot
                  fq_tgt[wr_ptr[IDX_W-1:0] + IDX_W'(s)]   <=
                     bundle.pc + addr_t'((s + 1) * INSN_BYTES);
               end
            end
         end
      end
   end

   for (genvar s = 0; s < ISSUE_W; s++)
   begin : g_out
      logic [IDX_W-1:0] rd_idx;

      assign rd_idx              = rd_ptr[IDX_W-1:0] + IDX_W'(s);
      assign id_valid_o[s]       = (used > PTR_W'(s));
      assign id_ins_o[s]         = fq_ins[rd_idx];
      assign id_pc_o[s]          = fq_pc[rd_idx];
      assign id_pred_taken_o[s]  = fq_taken[rd_idx];
      assign id_pred_target_o[s] = fq_tgt[rd_idx];
   end

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
/*
 Instruction fetch front end top level. Connects the PC generator, the
 branch predictor and the fetch queue to the memory, decode and redirect ports.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_top
   import fetch_cfg_pkg::*;
   import bpu_pkg::*;
#(
   parameter int FQ_DEPTH    = 8,
   parameter int BTB_ENTRIES = 16
)
(
   input  logic                      clk,
   input  logic                      reset_i,
   // Instruction memory
   output logic                      mem_req_valid_o,
   input  logic                      mem_req_ready_i,
   output addr_t                     mem_req_addr_o,
   input  logic                      mem_rsp_valid_i,
   input  logic [FETCH_W*INSN_W-1:0] mem_rsp_data_i,
   // Decode
   output logic  [ISSUE_W-1:0]       id_valid_o,
   output insn_t [ISSUE_W-1:0]       id_ins_o,
   output addr_t [ISSUE_W-1:0]       id_pc_o,
   output logic  [ISSUE_W-1:0]       id_pred_taken_o,
   output addr_t [ISSUE_W-1:0]       id_pred_target_o,
   input  logic  [CNT_W-1:0]         id_pop_cnt_i,
   // Redirect and predictor update
   input  logic                      flush_i,
   input  addr_t                     flush_tgt_i,
   input  logic                      bpu_wb_i,
   input  br_kind_e                  bpu_wb_kind_i,
   input  logic                      bpu_wb_taken_i,
   input  addr_t                     bpu_wb_pc_i,
   input  addr_t                     bpu_wb_target_i
);

   fetch_bundle_if bundle ();
   bpu_lookup_if   lookup ();

   fetch_pc_gen U_PC_GEN (
      .clk              (clk),
      .reset_i          (reset_i),
      .flush_i          (flush_i),
      .flush_tgt_i      (flush_tgt_i),
      .mem_req_valid_o  (mem_req_valid_o),
      .mem_req_ready_i  (mem_req_ready_i),
      .mem_req_addr_o   (mem_req_addr_o),
      .mem_rsp_valid_i  (mem_rsp_valid_i),
      .mem_rsp_data_i   (mem_rsp_data_i),
      .bundle           (bundle.pc_gen),
      .bpu              (lookup.requester)
   );

   branch_predictor #(
      .BTB_ENTRIES      (BTB_ENTRIES)
   ) U_BPU (
      .clk              (clk),
      .reset_i          (reset_i),
      .bpu              (lookup.predictor),
      .bpu_wb_i         (bpu_wb_i),
      .bpu_wb_kind_i    (bpu_wb_kind_i),
      .bpu_wb_taken_i   (bpu_wb_taken_i),
      .bpu_wb_pc_i      (bpu_wb_pc_i),
      .bpu_wb_target_i  (bpu_wb_target_i)
   );

   fetch_queue #(
      .FQ_DEPTH         (FQ_DEPTH)
   ) U_FQ (
      .clk              (clk),
      .reset_i          (reset_i),
      .flush_i          (flush_i),
      .bundle           (bundle.queue),
      .id_valid_o       (id_valid_o),
      .id_ins_o         (id_ins_o),
      .id_pc_o          (id_pc_o),
      .id_pred_taken_o  (id_pred_taken_o),
      .id_pred_target_o (id_pred_target_o),
      .id_pop_cnt_i     (id_pop_cnt_i)
   );

endmodule

`default_nettype wire
